/* verilog/core_settings.svh */
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// width of the integer data path
`define XLEN    32

// architectural registers, register 0 reads as zero
`define RF_REGS 32

// immediate payload carried with the decoded instruction
`define IMM_W   12

`endif

/* verilog/p_isa_types.sv */
`include "core_settings.svh"

package p_isa_types;

   typedef logic [4:0]        rf_add;  // register address
   typedef logic [`XLEN-1:0]  word_t;  // data word
   typedef logic [`IMM_W-1:0] imm_t;   // immediate payload
   typedef logic [2:0]        f_part;  // function code
   typedef logic [1:0]        ictrl;   // instruction control
   typedef logic              sctrl;   // source control, set selects immediate
   typedef logic [3:0]        fwd_t;   // forwarding flags for EX

   // function codes
   parameter f_part F_ADD = 3'd0;
   parameter f_part F_SUB = 3'd1;
   parameter f_part F_AND = 3'd2;
   parameter f_part F_OR  = 3'd3;
   parameter f_part F_XOR = 3'd4;
   parameter f_part F_SLL = 3'd5;
   parameter f_part F_MUL = 3'd6;   // late result, done in MA

   // ictrl bit positions
   parameter int ICTRL_WRD  = 0;    // instruction writes rd
   parameter int ICTRL_LATE = 1;    // result only available after MA

   // fwd_t bit positions
   parameter int FWD_EX_OP1 = 0;    // op1 from EXMA result
   parameter int FWD_EX_OP2 = 1;    // op2 from EXMA result
   parameter int FWD_WB_OP1 = 2;    // op1 from MAWB result
   parameter int FWD_WB_OP2 = 3;    // op2 from MAWB result

endpackage

/* verilog/p_pipe_regs.sv */
package p_pipe_regs;

   import p_isa_types::*;

   // decoded instruction from ID
   typedef struct packed {
      f_part              f;
      rf_add              rs1;
      rf_add              rs2;
      rf_add              rd;
      imm_t               payload;   // sign-extended when sctrl set
      p_isa_types::sctrl  sctrl;
      p_isa_types::ictrl  ictrl;     // zero means empty slot
   } idop_t;

   // operand stage register
   typedef struct packed {
      word_t              op1;
      word_t              op2;
      f_part              f;
      rf_add              rd;
      p_isa_types::ictrl  ictrl;
      fwd_t               fwd;       // late operand selection in EX
   } opex_t;

   // execute stage register
   typedef struct packed {
      word_t              val;       // ALU result, or op1 of a late instruction
      word_t              op2;
      f_part              f;
      rf_add              rd;
      p_isa_types::ictrl  ictrl;
   } exma_t;

   // memory-access stage register, feeds writeback
   typedef struct packed {
      word_t              val;
      rf_add              rd;
      p_isa_types::ictrl  ictrl;
   } mawb_t;

endpackage

/* verilog/register_file.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module register_file
   import p_isa_types::*, p_pipe_regs::*;
(
   input  logic  s_clk_i,      // core clock
   input  logic  arst_n_i,     // async reset, active low

   input  rf_add rs1_i,        // read address, port 1
   input  rf_add rs2_i,        // read address, port 2
   output word_t rd_data1_o,
   output word_t rd_data2_o,

   input  mawb_t wb_i          // writeback entry from MAWB
);

   word_t regs [`RF_REGS];
   logic  wr_en;

   // only real writers of a nonzero rd
   assign wr_en = wb_i.ictrl[ICTRL_WRD] && (wb_i.rd != '0);

   always_ff @(posedge s_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         for (int i = 0; i < `RF_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wb_i.rd] <= wb_i.val;
      end
   end

   // asynchronous reads, x0 hardwired
   assign rd_data1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
   assign rd_data2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

/* verilog/preparer.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module preparer
   import p_isa_types::*, p_pipe_regs::*;
(
   input  idop_t idop_i,       // incoming decoded instruction
   input  word_t p1_i,         // register file value for rs1
   input  word_t p2_i,         // register file value for rs2

   input  opex_t opex_i,       // instruction currently in OPEX
   input  exma_t exma_i,       // instruction currently in EXMA
   input  mawb_t mawb_i,       // instruction currently in MAWB

   output word_t operand1_o,
   output word_t operand2_o,
   output fwd_t  fwd_o,        // deferred selection for EX
   output logic  bubble_o      // late producer directly ahead
);

   logic  opex_wr, exma_wr, mawb_wr;
   logic  ex1, ex2, wb1, wb2;
   logic  bub1, bub2;
   word_t val1, val2;
   word_t imm_ext;

   // a stage only matters if it writes a nonzero rd, so x0 never matches
   assign opex_wr = opex_i.ictrl[ICTRL_WRD] && (opex_i.rd != '0);
   assign exma_wr = exma_i.ictrl[ICTRL_WRD] && (exma_i.rd != '0);
   assign mawb_wr = mawb_i.ictrl[ICTRL_WRD] && (mawb_i.rd != '0);

   assign imm_ext = {{(`XLEN-`IMM_W){idop_i.payload[`IMM_W-1]}}, idop_i.payload};

   // youngest producer wins
   function automatic void resolve(
      input  rf_add rs,
      input  word_t rf_val,
      output logic  ex_fwd,
      output logic  wb_fwd,
      output logic  bub,
      output word_t val
   );
      ex_fwd = 1'b0;
      wb_fwd = 1'b0;
      bub    = 1'b0;
      val    = rf_val;
      if (opex_wr && (rs == opex_i.rd)) begin
         if (opex_i.ictrl[ICTRL_LATE]) begin
            bub = 1'b1;           // product exists only after MA
         end else begin
            ex_fwd = 1'b1;        // take EXMA result next cycle
         end
      end else if (exma_wr && (rs == exma_i.rd)) begin
         wb_fwd = 1'b1;           // will sit in MAWB next cycle
      end else if (mawb_wr && (rs == mawb_i.rd)) begin
         val = mawb_i.val;        // rf write not yet visible
      end
   endfunction

   always_comb begin
      resolve(idop_i.rs1, p1_i, ex1, wb1, bub1, val1);
      resolve(idop_i.rs2, p2_i, ex2, wb2, bub2, val2);

      operand1_o             = val1;
      operand2_o             = val2;
      fwd_o                  = '0;
      fwd_o[FWD_EX_OP1]      = ex1;
      fwd_o[FWD_WB_OP1]      = wb1;
      fwd_o[FWD_EX_OP2]      = ex2;
      fwd_o[FWD_WB_OP2]      = wb2;

      // immediate operand, rs2 is ignored
      if (idop_i.sctrl) begin
         operand2_o          = imm_ext;
         fwd_o[FWD_EX_OP2]   = 1'b0;
         fwd_o[FWD_WB_OP2]   = 1'b0;
      end

      // empty slot never asks for a bubble
      bubble_o = (idop_i.ictrl != '0) && (bub1 || (bub2 && !idop_i.sctrl));
   end

endmodule

/* verilog/pipeline_op.sv */
`timescale 1ns/1ps

module pipeline_op
   import p_isa_types::*, p_pipe_regs::*;
(
   input  logic  s_clk_i,      // core clock
   input  logic  arst_n_i,     // async reset, active low

   input  idop_t idop_i,       // decoded instruction
   input  logic  in_valid_i,   // idop_i carries a real instruction
   input  logic  mem_wait_i,   // hold from MA

   input  word_t p1_i,         // register file read data
   input  word_t p2_i,

   input  exma_t exma_i,
   input  mawb_t mawb_i,

   output opex_t opex_o,
   output logic  stall_o       // ID must hold its instruction
);

   // OPEX register, split by write enable
   ictrl  ictrl_q;             // essential
   rf_add rd_q;                // auxiliary
   f_part f_q;
   word_t op1_q, op2_q;        // operand group
   fwd_t  fwd_q;

   logic  bubble, bubble_req;
   logic  stall_op, flush_op, op_empty;
   logic  we_esn, we_aux, we_fwd;
   word_t operand1, operand2;
   fwd_t  forward;
   ictrl  w_ictrl;
   word_t w_op1, w_op2;
   fwd_t  w_fwd;

   assign opex_o = '{op1: op1_q, op2: op2_q, f: f_q, rd: rd_q, ictrl: ictrl_q, fwd: fwd_q};

   preparer preparer_inst (
      .idop_i     (idop_i),
      .p1_i       (p1_i),
      .p2_i       (p2_i),
      .opex_i     (opex_o),
      .exma_i     (exma_i),
      .mawb_i     (mawb_i),
      .operand1_o (operand1),
      .operand2_o (operand2),
      .fwd_o      (forward),
      .bubble_o   (bubble)
   );

   assign bubble_req = bubble && in_valid_i;
   assign stall_o    = bubble_req || mem_wait_i;
   assign stall_op   = mem_wait_i;
   assign flush_op   = bubble_req && !stall_op;     // memory wait overrides the bubble
   assign op_empty   = !in_valid_i || (idop_i.ictrl == '0);

   assign we_esn = !stall_op;
   assign we_aux = !(flush_op || stall_op || op_empty);
   // pending MAWB operands must be grabbed before MAWB empties
   assign we_fwd = we_aux || ((fwd_q[FWD_WB_OP2:FWD_WB_OP1] != 2'b00) && stall_op);

   assign w_ictrl = (flush_op || op_empty) ? '0 : idop_i.ictrl;

   always_comb begin
      w_op1 = operand1;
      w_op2 = operand2;
      w_fwd = forward;
      if (stall_op) begin
         // capture writeback value into the held operands
         w_op1 = fwd_q[FWD_WB_OP1] ? mawb_i.val : op1_q;
         w_op2 = fwd_q[FWD_WB_OP2] ? mawb_i.val : op2_q;
         w_fwd = {2'b00, fwd_q[FWD_EX_OP2:FWD_EX_OP1]};   // EXMA holds too
      end
   end

   always_ff @(posedge s_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ictrl_q <= '0;
      end else if (we_esn) begin
         ictrl_q <= w_ictrl;
      end
   end

   always_ff @(posedge s_clk_i) begin
      if (we_aux) begin
         rd_q <= idop_i.rd;
         f_q  <= idop_i.f;
      end
   end

   always_ff @(posedge s_clk_i) begin
      if (we_fwd) begin
         op1_q <= w_op1;
         op2_q <= w_op2;
         fwd_q <= w_fwd;
      end
   end

endmodule

/* verilog/pipeline_ex.sv */
`timescale 1ns/1ps

module pipeline_ex
   import p_isa_types::*, p_pipe_regs::*;
(
   input  logic  s_clk_i,      // core clock
   input  logic  arst_n_i,     // async reset, active low

   input  opex_t opex_i,       // prepared instruction
   input  mawb_t mawb_i,       // writeback entry, forwarding source
   input  logic  mem_wait_i,   // hold EXMA

   output exma_t exma_o
);

   ictrl  ictrl_q;             // essential, reset
   word_t val_q, op2_q;
   f_part f_q;
   rf_add rd_q;

   word_t a1, a2, result;
   logic  we_esn, we_aux;

   assign exma_o = '{val: val_q, op2: op2_q, f: f_q, rd: rd_q, ictrl: ictrl_q};

   // resolve deferred operands
   assign a1 = opex_i.fwd[FWD_EX_OP1] ? val_q      :
               opex_i.fwd[FWD_WB_OP1] ? mawb_i.val : opex_i.op1;
   assign a2 = opex_i.fwd[FWD_EX_OP2] ? val_q      :
               opex_i.fwd[FWD_WB_OP2] ? mawb_i.val : opex_i.op2;

   always_comb begin
      case (opex_i.f)
         F_SUB:   result = a1 - a2;
         F_AND:   result = a1 & a2;
         F_OR:    result = a1 | a2;
         F_XOR:   result = a1 ^ a2;
         F_SLL:   result = a1 << a2[4:0];   // shamt in low 5 bits
         F_MUL:   result = a1;              // MA does the multiply
         default: result = a1 + a2;
      endcase
   end

   assign we_esn = !mem_wait_i;
   assign we_aux = !mem_wait_i && (opex_i.ictrl != '0);

   always_ff @(posedge s_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ictrl_q <= '0;
      end else if (we_esn) begin
         ictrl_q <= opex_i.ictrl;
      end
   end

   always_ff @(posedge s_clk_i) begin
      if (we_aux) begin
         val_q <= result;
         op2_q <= a2;           // second factor for a late op
         f_q   <= opex_i.f;
         rd_q  <= opex_i.rd;
      end
   end

endmodule

/* verilog/pipeline_ma.sv */
`timescale 1ns/1ps

module pipeline_ma
   import p_isa_types::*, p_pipe_regs::*;
(
   input  logic  s_clk_i,      // core clock
   input  logic  arst_n_i,     // async reset, active low

   input  exma_t exma_i,       // instruction leaving EX
   input  logic  mem_wait_i,   // memory not ready

   output mawb_t mawb_o        // writeback entry
);

   ictrl  ictrl_q;             // essential, reset
   word_t val_q;
   rf_add rd_q;

   word_t product;
   logic  is_mul;

   assign mawb_o = '{val: val_q, rd: rd_q, ictrl: ictrl_q};

   // low half of the product only
   assign product = exma_i.val * exma_i.op2;
   assign is_mul  = exma_i.ictrl[ICTRL_LATE] && (exma_i.f == F_MUL);

   always_ff @(posedge s_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ictrl_q <= '0;
      end else begin
         ictrl_q <= mem_wait_i ? '0 : exma_i.ictrl;   // empty slot while waiting
      end
   end

   always_ff @(posedge s_clk_i) begin
      if (!mem_wait_i && (exma_i.ictrl != '0)) begin
         val_q <= is_mul ? product : exma_i.val;
         rd_q  <= exma_i.rd;
      end
   end

endmodule

/* verilog/op_pipe_top.sv */
`timescale 1ns/1ps

module op_pipe_top
   import p_isa_types::*, p_pipe_regs::*;
(
   input  logic  s_clk_i,      // core clock
   input  logic  arst_n_i,     // async reset, active low

   input  idop_t idop_i,       // decoded instruction from ID
   input  logic  in_valid_i,
   input  logic  mem_wait_i,   // memory wait level

   output logic  stall_o,
   output logic  wb_valid_o,   // writeback strobe
   output rf_add wb_rd_o,
   output word_t wb_val_o
);

   word_t p1, p2;
   opex_t opex;
   exma_t exma;
   mawb_t mawb;

   // reads straight from ID addresses
   register_file register_file_inst (
      .s_clk_i    (s_clk_i),
      .arst_n_i   (arst_n_i),
      .rs1_i      (idop_i.rs1),
      .rs2_i      (idop_i.rs2),
      .rd_data1_o (p1),
      .rd_data2_o (p2),
      .wb_i       (mawb)
   );

   pipeline_op pipeline_op_inst (
      .s_clk_i    (s_clk_i),
      .arst_n_i   (arst_n_i),
      .idop_i     (idop_i),
      .in_valid_i (in_valid_i),
      .mem_wait_i (mem_wait_i),
      .p1_i       (p1),
      .p2_i       (p2),
      .exma_i     (exma),
      .mawb_i     (mawb),
      .opex_o     (opex),
      .stall_o    (stall_o)
   );

   pipeline_ex pipeline_ex_inst (
      .s_clk_i    (s_clk_i),
      .arst_n_i   (arst_n_i),
      .opex_i     (opex),
      .mawb_i     (mawb),
      .mem_wait_i (mem_wait_i),
      .exma_o     (exma)
   );

   pipeline_ma pipeline_ma_inst (
      .s_clk_i    (s_clk_i),
      .arst_n_i   (arst_n_i),
      .exma_i     (exma),
      .mem_wait_i (mem_wait_i),
      .mawb_o     (mawb)
   );

   assign wb_valid_o = mawb.ictrl[ICTRL_WRD];
   assign wb_rd_o    = mawb.rd;
   assign wb_val_o   = mawb.val;

endmodule

/* test/tb_op_pipe.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module tb_op_pipe
   import p_isa_types::*, p_pipe_regs::*;
;

   localparam int MAX_INSTR = 64;   // room in the golden image
   localparam int FIELDS    = 8;    // words per golden line

   // expected writeback, one per accepted writer
   typedef struct packed {
      rf_add rd;
      word_t val;
   } wb_exp_t;

   logic  s_clk_i, arst_n_i;
   idop_t idop_i;
   logic  in_valid_i, mem_wait_i;
   logic  stall_o, wb_valid_o;
   rf_add wb_rd_o;
   word_t wb_val_o;

   word_t   gold [0:FIELDS*MAX_INSTR-1];
   word_t   shadow [`RF_REGS];        // sequential register model
   wb_exp_t sb_q [$];                 // outstanding writebacks
   integer  seed = 32'h5a4a;
   int      n_instr, limit, cycles;
   logic    wait_en, run_active, bubble_seen;

   op_pipe_top op_pipe_top_inst (
      .s_clk_i    (s_clk_i),
      .arst_n_i   (arst_n_i),
      .idop_i     (idop_i),
      .in_valid_i (in_valid_i),
      .mem_wait_i (mem_wait_i),
      .stall_o    (stall_o),
      .wb_valid_o (wb_valid_o),
      .wb_rd_o    (wb_rd_o),
      .wb_val_o   (wb_val_o)
   );

   always #20 s_clk_i = ~s_clk_i;   // 40 ns period

   task automatic stop_failed();
      $display("Some tests failed");
      $fatal(1);
   endtask

   task automatic check_rd(input string name, input rf_add exp, input rf_add act);
      if (act !== exp) begin
         $display("[ERROR] %0t ns %s expected %0d actual %0d", $time, name, exp, act);
         stop_failed();
      end
   endtask

   task automatic check_word(input string name, input word_t exp, input word_t act);
      if (act !== exp) begin
         $display("[ERROR] %0t ns %s expected %h actual %h", $time, name, exp, act);
         stop_failed();
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("[ERROR] %0t ns %s expected %b actual %b", $time, name, exp, act);
         stop_failed();
      end
   endtask

   // sequential meaning of each function code
   function automatic word_t reference_result(input f_part f, input word_t a, input word_t b);
      case (f)
         F_SUB:   return a - b;
         F_AND:   return a & b;
         F_OR:    return a | b;
         F_XOR:   return a ^ b;
         F_SLL:   return a << b[4:0];
         F_MUL:   return a * b;        // low 32 bits
         default: return a + b;
      endcase
   endfunction

   // random memory wait, roughly one cycle in four
   always @(posedge s_clk_i) begin
      mem_wait_i <= wait_en ? (($random(seed) & 3) == 0) : 1'b0;
   end

   always @(posedge s_clk_i) begin
      if (run_active) begin
         cycles = cycles + 1;
         if (cycles >= limit) begin
            $display("timeout after %0d cycles, the pipeline stopped retiring", cycles);
            stop_failed();
         end
      end
   end

   // writeback monitor, outputs settled by the falling edge
   always @(negedge s_clk_i) begin
      wb_exp_t exp;
      if (arst_n_i && wb_valid_o) begin
         if (sb_q.size() == 0) begin
            $display("writeback to x%0d at %0t ns with nothing outstanding", wb_rd_o, $time);
            stop_failed();
         end else begin
            exp = sb_q.pop_front();
            check_rd("wb_rd_o", exp.rd, wb_rd_o);
            check_word("wb_val_o", exp.val, wb_val_o);
         end
      end
   end

   initial begin
      idop_t instr;
      word_t a, b, res;
      logic  accepted;
      logic  late_ahead, bubble_due;
      rf_add late_rd;
      s_clk_i     = 1'b0;
      arst_n_i    = 1'b0;
      idop_i      = '0;
      in_valid_i  = 1'b0;
      mem_wait_i  = 1'b0;
      wait_en     = 1'b0;
      run_active  = 1'b0;
      bubble_seen = 1'b0;
      late_ahead  = 1'b0;
      late_rd     = '0;
      cycles      = 0;
      for (int r = 0; r < `RF_REGS; r++) shadow[r] = '0;

      $readmemh("test/op_pipe_golden.txt", gold);
      n_instr = 0;
      while (n_instr < MAX_INSTR && !$isunknown(gold[FIELDS*n_instr])) n_instr++;
      if (n_instr == 0) begin
         $display("golden file missing or holds no instructions");
         stop_failed();
      end
      limit = 4 * n_instr + 100;

      repeat (16) @(posedge s_clk_i);
      arst_n_i <= 1'b1;

      // idle pipe after reset
      repeat (6) begin
         @(negedge s_clk_i);
         check_flag("stall_o", 1'b0, stall_o);
         check_flag("wb_valid_o", 1'b0, wb_valid_o);
      end

      @(posedge s_clk_i);
      wait_en    <= 1'b1;
      run_active <= 1'b1;
      for (int i = 0; i < n_instr; i++) begin
         instr.f       = gold[FIELDS*i][2:0];
         instr.rd      = gold[FIELDS*i+1][4:0];
         instr.rs1     = gold[FIELDS*i+2][4:0];
         instr.rs2     = gold[FIELDS*i+3][4:0];
         instr.payload = gold[FIELDS*i+4][`IMM_W-1:0];
         instr.sctrl   = gold[FIELDS*i+5][0];
         instr.ictrl   = gold[FIELDS*i+6][1:0];

         // shadow model cross-checks the golden column
         a = shadow[instr.rs1];
         b = instr.sctrl ? {{(`XLEN-`IMM_W){instr.payload[`IMM_W-1]}}, instr.payload}
                         : shadow[instr.rs2];
         res = reference_result(instr.f, a, b);
         check_word("golden expected value", res, gold[FIELDS*i+7]);

         // reader of a late result still sitting in OPEX waits one bubble
         bubble_due = late_ahead && (instr.ictrl != '0) &&
                      ((instr.rs1 == late_rd) || (!instr.sctrl && (instr.rs2 == late_rd)));

         idop_i     <= instr;
         in_valid_i <= 1'b1;
         accepted = 1'b0;
         while (!accepted) begin
            @(negedge s_clk_i);
            check_flag("stall_o", mem_wait_i || bubble_due, stall_o);
            if (!stall_o) begin
               accepted = 1'b1;
            end else if (!mem_wait_i) begin
               bubble_seen = 1'b1;   // bubble, not a memory wait
               bubble_due  = 1'b0;   // OPEX empties on this edge
            end
            @(posedge s_clk_i);
         end

         // taken on this edge
         if (instr.ictrl[ICTRL_WRD]) begin
            sb_q.push_back('{rd: instr.rd, val: res});
            if (instr.rd != '0) shadow[instr.rd] = res;
         end
         late_ahead = instr.ictrl[ICTRL_LATE] && instr.ictrl[ICTRL_WRD] && (instr.rd != '0);
         late_rd    = instr.rd;
      end
      in_valid_i <= 1'b0;
      idop_i     <= '0;

      while (sb_q.size() != 0) @(negedge s_clk_i);
      repeat (8) @(negedge s_clk_i);   // no stray writebacks
      wait_en <= 1'b0;

      if (bubble_seen && sb_q.size() == 0) begin
         $display("All tests passed");
         $finish;
      end else begin
         $display("stall_o never rose for an instruction behind a MUL");
         stop_failed();
      end
   end

endmodule

/* src.f */
+incdir+verilog
verilog/p_isa_types.sv
verilog/p_pipe_regs.sv
verilog/register_file.sv
verilog/preparer.sv
verilog/pipeline_op.sv
verilog/pipeline_ex.sv
verilog/pipeline_ma.sv
verilog/op_pipe_top.sv
test/tb_op_pipe.sv

/* test/op_pipe_golden.txt */
// columns, all hex: f rd rs1 rs2 imm sctrl ictrl expected_wb_value
// f: 0 add 1 sub 2 and 3 or 4 xor 5 sll 6 mul, ictrl 1 writes rd, 3 late (mul)
// independent immediates
0 01 00 00 005 1 1 00000005
0 02 00 00 00c 1 1 0000000c
0 03 00 00 ffd 1 1 fffffffd
3 04 00 00 0f0 1 1 000000f0
4 05 00 00 7ff 1 1 000007ff
0 06 00 00 800 1 1 fffff800
// dependencies at distance one, two and three
0 07 01 02 000 0 1 00000011
1 08 07 01 000 0 1 0000000c
2 09 07 04 000 0 1 00000010
4 0a 04 07 000 0 1 000000e1
5 0b 0a 00 004 1 1 00000e10
3 0c 0b 0a 000 0 1 00000ef1
1 0d 0c 0c 000 0 1 00000000
0 0e 03 0c 000 0 1 00000eee
5 0f 05 0b 000 0 1 07ff0000
// mul with consumers right behind and further back
6 10 01 02 000 0 3 0000003c
0 11 10 00 001 1 1 0000003d
6 12 11 03 000 0 3 ffffff49
1 13 00 12 000 0 1 000000b7
6 14 06 06 000 0 3 00400000
0 15 01 00 002 1 1 00000007
3 16 14 15 000 0 1 00400007
6 17 15 15 000 0 3 00000031
0 18 02 02 000 0 1 00000018
0 19 02 00 000 1 1 0000000c
4 1a 17 18 000 0 1 00000029
// writes to x0 retire but read back as zero
0 00 01 00 100 1 1 00000105
0 1b 00 01 000 0 1 00000005
6 00 02 02 000 0 3 00000090
3 1c 00 00 000 0 1 00000000
1 1d 1b 00 000 0 1 00000005
// chain through a mul
0 1e 1d 00 07f 1 1 00000084
6 1f 1e 1e 000 0 3 00004410
0 01 1f 1e 000 0 1 00004494
5 02 01 08 000 0 1 04494000
1 03 02 01 000 0 1 0448fb6c
